// ==== verif/pdp8Patterns.txt ====
# columns: command, switch value (octal), light to check, expected value (octal)
# commands L D E S C P=stop W=wait for halt; lights a=AC m=MA b=MB k=link:AC x=none
# memory reference program at 0200 with data at 0220 and auto-index pointer at 0010
L 0220 x 0
D 0123 x 0
D 7777 x 0
D 0230 x 0
D 0000 x 0
D 0456 x 0
L 0010 x 0
D 0223 x 0
L 0200 x 0
D 1220 x 0
D 1410 x 0
D 3240 x 0
D 2221 x 0
D 7402 x 0
D 4250 x 0
L 0230 x 0
D 3241 x 0
D 7402 x 0
L 0251 x 0
D 1220 x 0
D 5622 x 0
L 0200 x 0
S 0000 x 0
W 0000 k 00000
W 0000 m 0232
L 0240 b 0601
L 0241 b 0123
L 0250 b 0206
L 0010 b 0224
L 0221 b 0000
# group 1 operate at 0300, each rotate ends in a halt
L 0340 x 0
D 5432 x 0
L 0300 x 0
D 1340 x 0
D 7004 x 0
D 7402 x 0
D 7012 x 0
D 7402 x 0
D 7041 x 0
D 7402 x 0
D 7010 x 0
D 7402 x 0
D 7006 x 0
D 7402 x 0
D 7002 x 0
D 7402 x 0
D 7300 x 0
D 7402 x 0
L 0300 x 0
S 0000 x 0
W 0000 k 13064
C 0000 x 0
W 0000 k 02615
C 0000 x 0
W 0000 k 05163
C 0000 x 0
W 0000 k 12471
C 0000 x 0
W 0000 k 12346
C 0000 x 0
W 0000 k 14623
C 0000 x 0
W 0000 k 00000
# group 2 skips at 0400, an IAC marker follows each skip
L 0400 x 0
D 7440 x 0
D 7001 x 0
D 7402 x 0
D 7450 x 0
D 7001 x 0
D 7402 x 0
D 7500 x 0
D 7001 x 0
D 7402 x 0
D 7040 x 0
D 7500 x 0
D 7001 x 0
D 7510 x 0
D 7001 x 0
D 7402 x 0
D 7420 x 0
D 7001 x 0
D 7430 x 0
D 7001 x 0
D 7402 x 0
D 7001 x 0
D 7420 x 0
D 7001 x 0
D 7430 x 0
D 7001 x 0
D 7402 x 0
D 7606 x 0
L 0400 x 0
S 0000 x 0
W 0000 k 00000
C 0000 x 0
W 0000 k 00001
C 0000 x 0
W 0000 k 00002
C 0000 x 0
W 0000 k 07776
C 0000 x 0
W 0000 k 07777
C 0000 x 0
W 0000 k 10001
C 5252 x 0
W 0000 k 15252
# tight jmp loop at 0500, stop, continue, stop again
L 0500 x 0
D 5300 x 0
L 0500 x 0
S 0000 x 0
P 0000 x 0
W 0000 m 0500
C 0000 x 0
P 0000 x 0
W 0000 m 0500

// ==== pdp8Top.f ====
logic/pdp8IsaPkg.sv
logic/pdp8CtlPkg.sv
logic/coreMemory.sv
logic/pdp8Operate.sv
logic/pdp8Console.sv
logic/pdp8Sequencer.sv
logic/pdp8Datapath.sv
logic/pdp8Top.sv
verif/pdp8Tb.sv

// ==== Bender.yml ====
package:
  name: pdp8

sources:
  - logic/pdp8IsaPkg.sv
  - logic/pdp8CtlPkg.sv
  - logic/coreMemory.sv
  - logic/pdp8Operate.sv
  - logic/pdp8Console.sv
  - logic/pdp8Sequencer.sv
  - logic/pdp8Datapath.sv
  - logic/pdp8Top.sv
  - target: test
    files:
      - verif/pdp8Tb.sv

// ==== verif/pdp8Tb.sv ====
// testbench with console key tasks, pattern file reader, random deposit and examine test, lamp walk
`timescale 1ns/100ps

module pdp8Tb;

    logic                CLOCK;
    logic                RESET;
    pdp8CtlPkg::consoleS console;            // front panel switches and keys
    pdp8CtlPkg::panelS   panel;              // lights
    integer              seed;
    int                  errors;
    int                  checks;

    pdp8Top dut0 (
        .CLOCK(CLOCK), .RESET(RESET), .i_console(console), .o_panel(panel)
    );

    initial begin
        CLOCK = 1'b0;
        forever #4 CLOCK = ~CLOCK;           // 8 ns period
    end

    ////////////////////////////////////////////////////////////
    // checking
    task automatic compareValue(input string what, input logic [12:0] actual,
                                input logic [12:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %0d ns: %s is %o, expected %o", $time, what, actual, expected);
        end
    endtask

    // one clock strobe on a key, the switch value stays on the panel
    task automatic pressKey(input logic [7:0] key, input pdp8IsaPkg::wordT sw);
        console.switchReg = sw;
        case (key)
            "L": console.loadAddr = 1'b1;
            "D": console.deposit  = 1'b1;
            "E": console.examine  = 1'b1;
            "S": console.start    = 1'b1;
            "C": console.cont     = 1'b1;
            "P": console.stop     = 1'b1;
            default: ;
        endcase
        @(posedge CLOCK);
        #1;
        console.loadAddr = 1'b0;
        console.deposit  = 1'b0;
        console.examine  = 1'b0;
        console.start    = 1'b0;
        console.cont     = 1'b0;
        console.stop     = 1'b0;
    endtask

    // console memory cycle is back in halt 6 clocks after the strobe
    task automatic waitMemCycle();
        repeat (5) begin
            @(posedge CLOCK);
            #1;
        end
    endtask

    task automatic waitRun(input logic level, input int limit);
        int count;
        count = 0;
        while (panel.run !== level && count < limit) begin
            @(posedge CLOCK);
            #1;
            count++;
        end
        if (panel.run !== level) begin
            errors++;
            $display("timeout: run did not go %s within %0d clocks",
                     level ? "high" : "low", limit);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // one pattern line, command first, then the light check
    task automatic applyPattern(input int lineNo, input logic [7:0] cmd,
                                input pdp8IsaPkg::wordT sw, input logic [7:0] light,
                                input logic [12:0] expected);
        case (cmd)
            "L", "D", "E": begin
                pressKey(cmd, sw);
                waitMemCycle();
            end
            "S", "C": begin
                pressKey(cmd, sw);
                waitRun(1'b1, 20);           // run lamp comes on
            end
            "P": pressKey(cmd, sw);          // stop lands at end of instruction
            "W": waitRun(1'b0, 2000);        // wait for halt
            default: begin
                errors++;
                $display("pattern line %0d has unknown command %c", lineNo, cmd);
            end
        endcase
        case (light)
            "a": compareValue($sformatf("line %0d AC", lineNo), {1'b0, panel.ac}, expected);
            "m": compareValue($sformatf("line %0d MA", lineNo), {1'b0, panel.ma}, expected);
            "b": compareValue($sformatf("line %0d MB", lineNo), {1'b0, panel.mb}, expected);
            "k": compareValue($sformatf("line %0d link:AC", lineNo),
                              {panel.link, panel.ac}, expected);
            "x": ;                           // don't care
            default: begin
                errors++;
                $display("pattern line %0d names unknown light %c", lineNo, light);
            end
        endcase
    endtask

    task automatic readPatterns();
        int                fd;
        int                lineNo;
        int                used;
        string             line;
        logic [7:0]        cmd;
        logic [7:0]        light;
        pdp8IsaPkg::wordT  sw;
        logic [12:0]       expected;
        fd = $fopen("verif/pdp8Patterns.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open verif/pdp8Patterns.txt");
            return;
        end
        lineNo = 0;
        used   = 0;
        while ($fgets(line, fd) != 0) begin
            lineNo++;
            if (line.len() < 2 || line[0] == "#") continue;   // blank or comment
            if ($sscanf(line, "%c %o %c %o", cmd, sw, light, expected) != 4) begin
                errors++;
                $display("pattern line %0d could not be parsed", lineNo);
            end else begin
                applyPattern(lineNo, cmd, sw, light, expected);
                used++;
            end
        end
        $fclose(fd);
        if (used == 0) begin
            errors++;
            $display("pattern file held no commands");
        end
    endtask

    ////////////////////////////////////////////////////////////
    task automatic checkReset();
        compareValue("run after reset", {12'd0, panel.run}, 13'd0);
        compareValue("AC after reset", {1'b0, panel.ac}, 13'd0);
        compareValue("MA after reset", {1'b0, panel.ma}, 13'd0);
        compareValue("MB after reset", {1'b0, panel.mb}, 13'd0);
    endtask

    // eight random deposits, then read them back, MA steps each time
    task automatic depositExamineRandom(input pdp8IsaPkg::wordT base);
        pdp8IsaPkg::wordT data [8];
        pdp8IsaPkg::wordT addr;
        int               rnd;
        pressKey("L", base);
        waitMemCycle();
        for (int i = 0; i < 8; i++) begin
            rnd     = $random(seed);
            data[i] = rnd[11:0];
            addr    = base + i[11:0];
            pressKey("D", data[i]);
            waitMemCycle();
            compareValue($sformatf("deposit %0d MB", i), {1'b0, panel.mb}, {1'b0, data[i]});
            compareValue($sformatf("deposit %0d MA", i), {1'b0, panel.ma}, {1'b0, addr});
        end
        pressKey("L", base);
        waitMemCycle();
        for (int i = 0; i < 8; i++) begin
            addr = base + i[11:0];
            pressKey("E", 12'd0);
            waitMemCycle();
            compareValue($sformatf("examine %0d MB", i), {1'b0, panel.mb}, {1'b0, data[i]});
            compareValue($sformatf("examine %0d MA", i), {1'b0, panel.ma}, {1'b0, addr});
        end
    endtask

    // a tad indirect then halt walks the lamps through fetch defer exec fetch
    task automatic checkLampWalk();
        logic [11:0]        walk;             // last four lamp states, oldest on top
        logic [2:0]         lamps;
        logic [12:0]        steps;
        int                 count;
        pdp8IsaPkg::opcodeE execIr;
        walk   = '0;
        steps  = '0;
        count  = 0;
        execIr = pdp8IsaPkg::OP_AND;
        pressKey("L", 12'o0720);
        waitMemCycle();
        pressKey("D", 12'o0721);             // pointer
        waitMemCycle();
        pressKey("D", 12'o0042);             // operand
        waitMemCycle();
        pressKey("L", 12'o0700);
        waitMemCycle();
        pressKey("D", 12'o1720);             // tad i 0720
        waitMemCycle();
        pressKey("D", 12'o7402);             // hlt
        waitMemCycle();
        pressKey("L", 12'o0700);
        waitMemCycle();
        pressKey("S", 12'o0000);
        do begin
            @(posedge CLOCK);
            #1;
            count++;
            lamps = {panel.fetch, panel.defer, panel.exec};
            if (panel.run === 1'b1 && lamps !== walk[2:0]) begin
                walk = {walk[8:0], lamps};
                steps++;
                if (panel.exec === 1'b1) execIr = panel.ir;
            end
        end while (panel.run === 1'b1 && count < 200);
        if (panel.run !== 1'b0) begin
            errors++;
            $display("timeout: lamp walk program did not halt within 200 clocks");
        end
        compareValue("lamp steps", steps, 13'd4);
        compareValue("lamp walk", {1'b0, walk}, 13'o04214);
        compareValue("IR in exec", {10'd0, execIr}, {10'd0, pdp8IsaPkg::OP_TAD});
        compareValue("IR at halt", {10'd0, panel.ir}, {10'd0, pdp8IsaPkg::OP_OPR});
        compareValue("AC at halt", {1'b0, panel.ac}, 13'o0042);
    endtask

    initial begin
        console = '0;
        RESET   = 1'b1;
        seed    = 32'h85ee;
        errors  = 0;
        checks  = 0;
        repeat (10) @(posedge CLOCK);
        #1;
        RESET = 1'b0;
        checkReset();
        depositExamineRandom(12'o0600);
        readPatterns();                      // programs, operate groups, stop and continue
        checkLampWalk();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== logic/pdp8Top.sv ====
// processor top level joining console, sequencer, datapath and core memory
`timescale 1ns/100ps

module pdp8Top (
    input  logic                CLOCK,
    input  logic                RESET,
    input  pdp8CtlPkg::consoleS i_console,
    output pdp8CtlPkg::panelS   o_panel
);

    pdp8CtlPkg::consoleCmdE cmd;
    pdp8IsaPkg::wordT       switchReg;
    logic                   stopPending, idleHalted, endOfInstr;
    pdp8CtlPkg::majorStateE majorState;
    pdp8CtlPkg::timeStateE  timeState;
    pdp8IsaPkg::instrU      instr;
    logic                   isHalt;
    pdp8IsaPkg::wordT       memAddr, memWdata, memRdata;
    logic                   memWe;

    pdp8Console console0 (
        .CLOCK(CLOCK), .RESET(RESET), .i_console(i_console),
        .i_idleHalted(idleHalted), .i_endOfInstr(endOfInstr),
        .o_cmd(cmd), .o_switchReg(switchReg), .o_stopPending(stopPending)
    );

    pdp8Sequencer sequencer0 (
        .CLOCK(CLOCK), .RESET(RESET), .i_cmd(cmd), .i_stopPending(stopPending),
        .i_instr(instr), .i_isHalt(isHalt), .o_majorState(majorState),
        .o_timeState(timeState), .o_idleHalted(idleHalted), .o_endOfInstr(endOfInstr)
    );

    pdp8Datapath datapath0 (
        .CLOCK(CLOCK), .RESET(RESET), .i_majorState(majorState), .i_timeState(timeState),
        .i_cmd(cmd), .i_switchReg(switchReg), .i_memRdata(memRdata),
        .o_memAddr(memAddr), .o_memWdata(memWdata), .o_memWe(memWe),
        .o_instr(instr), .o_isHalt(isHalt), .o_ac(o_panel.ac), .o_ma(o_panel.ma),
        .o_mb(o_panel.mb), .o_link(o_panel.link), .o_ir(o_panel.ir)
    );

    coreMemory core0 (
        .CLOCK(CLOCK), .i_addr(memAddr), .i_wdata(memWdata), .i_we(memWe),
        .o_rdata(memRdata)
    );

    // state lamps
    assign o_panel.fetch = (majorState == pdp8CtlPkg::MS_FETCH);
    assign o_panel.defer = (majorState == pdp8CtlPkg::MS_DEFER);
    assign o_panel.exec  = (majorState == pdp8CtlPkg::MS_EXEC);
    assign o_panel.run   = o_panel.fetch | o_panel.defer | o_panel.exec;

endmodule

// ==== logic/pdp8Datapath.sv ====
// accumulator, link, program counter, memory address, memory buffer and instruction registers
`timescale 1ns/100ps

module pdp8Datapath (
    input  logic                   CLOCK,
    input  logic                   RESET,
    input  pdp8CtlPkg::majorStateE i_majorState,
    input  pdp8CtlPkg::timeStateE  i_timeState,
    input  pdp8CtlPkg::consoleCmdE i_cmd,
    input  pdp8IsaPkg::wordT       i_switchReg,
    input  pdp8IsaPkg::wordT       i_memRdata,
    output pdp8IsaPkg::wordT       o_memAddr,
    output pdp8IsaPkg::wordT       o_memWdata,
    output logic                   o_memWe,
    output pdp8IsaPkg::instrU      o_instr,
    output logic                   o_isHalt,
    output pdp8IsaPkg::wordT       o_ac,
    output pdp8IsaPkg::wordT       o_ma,
    output pdp8IsaPkg::wordT       o_mb,
    output logic                   o_link,
    output pdp8IsaPkg::opcodeE     o_ir
);

    pdp8IsaPkg::wordT   ac, pc, ma, pcNext, maNext, effAddr;
    pdp8IsaPkg::instrU  mb;
    pdp8IsaPkg::opcodeE ir;
    logic               link;
    pdp8IsaPkg::wordT   tadAc, g1Ac, g2Ac;
    logic               tadLink, g1Link, g2Skip;

    pdp8Operate operate0 (
        .i_ac(ac), .i_mb(mb), .i_switchReg(i_switchReg), .i_link(link),
        .o_tadAc(tadAc), .o_tadLink(tadLink), .o_g1Ac(g1Ac), .o_g1Link(g1Link),
        .o_g2Ac(g2Ac), .o_g2Skip(g2Skip)
    );

    // page zero or current page
    assign effAddr = {mb.memRef.page ? ma[11:7] : 5'd0, mb.memRef.offset};

    ////////////////////////////////////////////////////////////
    // pc and ma next values, ma next also addresses the core
    always_comb begin
        pcNext = pc;
        maNext = ma;
        case (i_timeState)
            pdp8CtlPkg::TS_IDLE: if (i_majorState == pdp8CtlPkg::MS_HALT) begin
                case (i_cmd)
                    pdp8CtlPkg::CMD_LOAD_ADDR: begin
                        pcNext = i_switchReg;
                        maNext = i_switchReg;
                    end
                    pdp8CtlPkg::CMD_EXAMINE, pdp8CtlPkg::CMD_DEPOSIT: begin
                        pcNext = pc + 12'd1;
                        maNext = pc;
                    end
                    pdp8CtlPkg::CMD_START, pdp8CtlPkg::CMD_CONTINUE: maNext = pc;
                    default: ;
                endcase
            end
            pdp8CtlPkg::TS_TS2: if (i_majorState == pdp8CtlPkg::MS_FETCH) pcNext = pc + 12'd1;
            pdp8CtlPkg::TS_TS4: case (i_majorState)
                pdp8CtlPkg::MS_FETCH: begin
                    if (ir == pdp8IsaPkg::OP_JMP && !mb.memRef.indirect) pcNext = effAddr;
                    if (ir == pdp8IsaPkg::OP_OPR && mb.operate.group && !mb.operate.iac && g2Skip)
                        pcNext = pc + 12'd1;
                    if (ir == pdp8IsaPkg::OP_IOT || ir == pdp8IsaPkg::OP_OPR ||
                        (ir == pdp8IsaPkg::OP_JMP && !mb.memRef.indirect))
                        maNext = pcNext;                          // next fetch
                    else
                        maNext = effAddr;                         // defer or exec follows
                end
                pdp8CtlPkg::MS_DEFER: begin
                    if (ir == pdp8IsaPkg::OP_JMP) pcNext = mb;
                    maNext = mb;                                  // pointer is the target
                end
                pdp8CtlPkg::MS_EXEC: begin
                    if (ir == pdp8IsaPkg::OP_ISZ && mb == 12'd0) pcNext = pc + 12'd1;
                    if (ir == pdp8IsaPkg::OP_JMS) pcNext = ma + 12'd1;
                    maNext = pcNext;
                end
                default: ;                                        // console cycles keep ma
            endcase
            default: ;
        endcase
    end

    ////////////////////////////////////////////////////////////
    always_ff @(posedge CLOCK) begin
        if (RESET) begin
            ac   <= '0;
            link <= 1'b0;
            pc   <= '0;
            ma   <= '0;
            mb   <= '0;
            ir   <= pdp8IsaPkg::OP_AND;
        end else begin
            pc <= pcNext;
            ma <= maNext;
            case (i_timeState)
                pdp8CtlPkg::TS_IDLE: if (i_majorState == pdp8CtlPkg::MS_HALT &&
                                         i_cmd == pdp8CtlPkg::CMD_START) begin
                    ac   <= '0;
                    link <= 1'b0;
                end
                pdp8CtlPkg::TS_TS1: mb <= i_memRdata;             // read data ready end of ts1
                pdp8CtlPkg::TS_TS2: case (i_majorState)
                    pdp8CtlPkg::MS_FETCH: ir <= mb.memRef.opcode;
                    pdp8CtlPkg::MS_DEFER: if (ma >= pdp8IsaPkg::AUTO_INDEX_LO &&
                                             ma <= pdp8IsaPkg::AUTO_INDEX_HI) mb <= mb + 12'd1;
                    pdp8CtlPkg::MS_EXEC: case (ir)
                        pdp8IsaPkg::OP_ISZ: mb <= mb + 12'd1;
                        pdp8IsaPkg::OP_DCA: mb <= ac;
                        pdp8IsaPkg::OP_JMS: mb <= pc;             // return address
                        default: ;
                    endcase
                    pdp8CtlPkg::MS_DEPOSIT: mb <= i_switchReg;
                    default: ;
                endcase
                pdp8CtlPkg::TS_TS4: begin
                    if (i_majorState == pdp8CtlPkg::MS_FETCH && ir == pdp8IsaPkg::OP_OPR) begin
                        if (!mb.operate.group) begin
                            ac   <= g1Ac;
                            link <= g1Link;
                        end else if (!mb.operate.iac) begin
                            ac <= g2Ac;
                        end
                    end else if (i_majorState == pdp8CtlPkg::MS_EXEC) begin
                        case (ir)
                            pdp8IsaPkg::OP_AND: ac <= ac & mb;
                            pdp8IsaPkg::OP_TAD: begin
                                ac   <= tadAc;
                                link <= tadLink;
                            end
                            pdp8IsaPkg::OP_DCA: ac <= '0;
                            default: ;
                        endcase
                    end
                end
                default: ;
            endcase
        end
    end

    assign o_memAddr  = maNext;            // registered core read lines up with ma
    assign o_memWdata = mb;
    assign o_memWe    = (i_timeState == pdp8CtlPkg::TS_TS3);
    assign o_instr    = mb;
    assign o_isHalt   = (ir == pdp8IsaPkg::OP_OPR) &&
                        ((mb & pdp8IsaPkg::HLT_MASK) == pdp8IsaPkg::HLT_MATCH);
    assign o_ac       = ac;
    assign o_ma       = ma;
    assign o_mb       = mb;
    assign o_link     = link;
    assign o_ir       = ir;

endmodule

// ==== logic/pdp8Sequencer.sv ====
// time state and major state controller choosing the next memory cycle
`timescale 1ns/100ps

module pdp8Sequencer (
    input  logic                   CLOCK,
    input  logic                   RESET,
    input  pdp8CtlPkg::consoleCmdE i_cmd,
    input  logic                   i_stopPending,
    input  pdp8IsaPkg::instrU      i_instr,
    input  logic                   i_isHalt,
    output pdp8CtlPkg::majorStateE o_majorState,
    output pdp8CtlPkg::timeStateE  o_timeState,
    output logic                   o_idleHalted,
    output logic                   o_endOfInstr
);

    pdp8CtlPkg::majorStateE nextMajor, nextMajorQ;
    pdp8IsaPkg::opcodeE     op;
    logic                   endInstr;
    logic                   jmpDefer;      // instruction in defer is a jmp

    assign op           = i_instr.memRef.opcode;
    assign o_idleHalted = (o_majorState == pdp8CtlPkg::MS_HALT) &&
                          (o_timeState == pdp8CtlPkg::TS_IDLE);
    assign o_endOfInstr = endInstr && (o_timeState == pdp8CtlPkg::TS_TS3);

    // decision taken in ts3
    always_comb begin
        endInstr  = 1'b0;
        nextMajor = pdp8CtlPkg::MS_HALT;   // console cycles fall back to halt
        case (o_majorState)
            pdp8CtlPkg::MS_FETCH: begin
                if (op == pdp8IsaPkg::OP_IOT || op == pdp8IsaPkg::OP_OPR)
                    endInstr = 1'b1;
                else if (i_instr.memRef.indirect)
                    nextMajor = pdp8CtlPkg::MS_DEFER;
                else if (op == pdp8IsaPkg::OP_JMP)
                    endInstr = 1'b1;                        // direct jmp done in fetch
                else
                    nextMajor = pdp8CtlPkg::MS_EXEC;
            end
            pdp8CtlPkg::MS_DEFER: begin
                if (jmpDefer) endInstr = 1'b1;
                else          nextMajor = pdp8CtlPkg::MS_EXEC;
            end
            pdp8CtlPkg::MS_EXEC: endInstr = 1'b1;
            default: ;
        endcase
        if (endInstr && !i_isHalt && !i_stopPending) nextMajor = pdp8CtlPkg::MS_FETCH;
    end

    always_ff @(posedge CLOCK) begin
        if (RESET) begin
            o_majorState <= pdp8CtlPkg::MS_HALT;
            o_timeState  <= pdp8CtlPkg::TS_IDLE;
            nextMajorQ   <= pdp8CtlPkg::MS_HALT;
            jmpDefer     <= 1'b0;
        end else begin
            case (o_timeState)
                pdp8CtlPkg::TS_IDLE: begin
                    if (o_majorState != pdp8CtlPkg::MS_HALT) begin
                        o_timeState <= pdp8CtlPkg::TS_TS1;        // running, one idle clock
                    end else if (i_cmd != pdp8CtlPkg::CMD_NONE) begin
                        o_timeState <= pdp8CtlPkg::TS_TS1;
                        case (i_cmd)
                            pdp8CtlPkg::CMD_DEPOSIT: o_majorState <= pdp8CtlPkg::MS_DEPOSIT;
                            pdp8CtlPkg::CMD_START,
                            pdp8CtlPkg::CMD_CONTINUE: o_majorState <= pdp8CtlPkg::MS_FETCH;
                            default: o_majorState <= pdp8CtlPkg::MS_EXAMINE;  // also load addr
                        endcase
                    end
                end
                pdp8CtlPkg::TS_TS1: o_timeState <= pdp8CtlPkg::TS_TS2;
                pdp8CtlPkg::TS_TS2: o_timeState <= pdp8CtlPkg::TS_TS3;
                pdp8CtlPkg::TS_TS3: begin
                    nextMajorQ  <= nextMajor;                     // stop clears after ts3
                    if (o_majorState == pdp8CtlPkg::MS_FETCH) jmpDefer <= (op == pdp8IsaPkg::OP_JMP);
                    o_timeState <= pdp8CtlPkg::TS_TS4;
                end
                default: begin
                    o_majorState <= nextMajorQ;
                    o_timeState  <= pdp8CtlPkg::TS_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== logic/pdp8Console.sv ====
// front panel command arbiter with switch register copy and stop request latch
`timescale 1ns/100ps

module pdp8Console (
    input  logic                   CLOCK,
    input  logic                   RESET,
    input  pdp8CtlPkg::consoleS    i_console,
    input  logic                   i_idleHalted,
    input  logic                   i_endOfInstr,
    output pdp8CtlPkg::consoleCmdE o_cmd,
    output pdp8IsaPkg::wordT       o_switchReg,
    output logic                   o_stopPending
);

    pdp8CtlPkg::consoleCmdE cmdNext;
    logic                   accept;        // halted and no command in flight
    logic                   running;       // start or continue issued, not yet halted

    assign accept = i_idleHalted && (o_cmd == pdp8CtlPkg::CMD_NONE);

    // fixed priority among the keys
    always_comb begin
        cmdNext = pdp8CtlPkg::CMD_NONE;
        if (i_console.loadAddr)     cmdNext = pdp8CtlPkg::CMD_LOAD_ADDR;
        else if (i_console.examine) cmdNext = pdp8CtlPkg::CMD_EXAMINE;
        else if (i_console.deposit) cmdNext = pdp8CtlPkg::CMD_DEPOSIT;
        else if (i_console.cont)    cmdNext = pdp8CtlPkg::CMD_CONTINUE;
        else if (i_console.start)   cmdNext = pdp8CtlPkg::CMD_START;
    end

    always_ff @(posedge CLOCK) begin
        if (RESET) begin
            o_cmd         <= pdp8CtlPkg::CMD_NONE;
            running       <= 1'b0;
            o_stopPending <= 1'b0;
        end else begin
            o_cmd <= accept ? cmdNext : pdp8CtlPkg::CMD_NONE;   // one clock pulse
            if (accept && (cmdNext == pdp8CtlPkg::CMD_START ||
                           cmdNext == pdp8CtlPkg::CMD_CONTINUE))
                running <= 1'b1;
            else if (accept)
                running <= 1'b0;                                // back in halt
            if (i_console.stop && running)         o_stopPending <= 1'b1;
            else if (i_endOfInstr || !running)     o_stopPending <= 1'b0;
        end
    end

    // switches frozen during a console memory cycle
    always_ff @(posedge CLOCK) begin
        if (accept || running) o_switchReg <= i_console.switchReg;
    end

endmodule

// ==== logic/pdp8Operate.sv ====
// combinational tad adder, group 1 operate and group 2 skip logic
`timescale 1ns/100ps

module pdp8Operate (
    input  pdp8IsaPkg::wordT i_ac,
    input  pdp8IsaPkg::wordT i_mb,
    input  pdp8IsaPkg::wordT i_switchReg,
    input  logic             i_link,
    output pdp8IsaPkg::wordT o_tadAc,
    output logic             o_tadLink,
    output pdp8IsaPkg::wordT o_g1Ac,
    output logic             o_g1Link,
    output pdp8IsaPkg::wordT o_g2Ac,
    output logic             o_g2Skip
);

    pdp8IsaPkg::instrU mb;
    pdp8IsaPkg::wordT  acRaw;
    logic              linkRaw;

    assign mb = i_mb;

    // carry out toggles the link
    assign {o_tadLink, o_tadAc} = {i_link, i_ac} + {1'b0, i_mb};

    // clear, complement, then increment
    assign {linkRaw, acRaw} = {(mb.operate.cllSma ? 1'b0 : i_link) ^ mb.operate.cmlSnl,
                               (mb.operate.cla ? 12'd0 : i_ac) ^ {12{mb.operate.cmaSza}}}
                              + {12'd0, mb.operate.iac};

    always_comb begin
        case ({mb.operate.rarRev, mb.operate.ralOsr, mb.operate.bswHlt})
            3'b001:  {o_g1Link, o_g1Ac} = {linkRaw, acRaw[5:0], acRaw[11:6]};  // bsw
            3'b010:  {o_g1Link, o_g1Ac} = {acRaw, linkRaw};                    // ral
            3'b011:  {o_g1Link, o_g1Ac} = {acRaw[10:0], linkRaw, acRaw[11]};   // rtl
            3'b100:  {o_g1Link, o_g1Ac} = {acRaw[0], linkRaw, acRaw[11:1]};    // rar
            3'b101:  {o_g1Link, o_g1Ac} = {acRaw[1:0], linkRaw, acRaw[11:2]};  // rtr
            default: {o_g1Link, o_g1Ac} = {linkRaw, acRaw};                    // no rotate
        endcase
    end

    // or of the conditions, flipped by the reverse bit
    assign o_g2Skip = ((mb.operate.cllSma & i_ac[11]) |
                       (mb.operate.cmaSza & (i_ac == 12'd0)) |
                       (mb.operate.cmlSnl & i_link)) ^ mb.operate.rarRev;

    assign o_g2Ac = (mb.operate.cla ? 12'd0 : i_ac) | (mb.operate.ralOsr ? i_switchReg : 12'd0);

endmodule

// ==== logic/coreMemory.sv ====
// core store with registered read and synchronous write
`timescale 1ns/100ps

module coreMemory (
    input  logic             CLOCK,
    input  pdp8IsaPkg::wordT i_addr,
    input  pdp8IsaPkg::wordT i_wdata,
    input  logic             i_we,
    output pdp8IsaPkg::wordT o_rdata
);

    pdp8IsaPkg::wordT mem [pdp8IsaPkg::MEM_WORDS];

    // block ram style, read data one clock after the address
    always_ff @(posedge CLOCK) begin
        if (i_we) mem[i_addr] <= i_wdata;    // ts3 write back
        o_rdata <= mem[i_addr];
    end

endmodule

// ==== logic/pdp8CtlPkg.sv ====
// control package with major and time states, console command, console input and panel structs
package pdp8CtlPkg;

    typedef enum logic [2:0] {
        MS_HALT, MS_FETCH, MS_DEFER, MS_EXEC, MS_DEPOSIT, MS_EXAMINE
    } majorStateE;

    // every memory cycle walks idle then ts1..ts4
    typedef enum logic [2:0] {
        TS_IDLE, TS_TS1, TS_TS2, TS_TS3, TS_TS4
    } timeStateE;

    typedef enum logic [2:0] {
        CMD_NONE, CMD_LOAD_ADDR, CMD_DEPOSIT, CMD_EXAMINE, CMD_START, CMD_CONTINUE
    } consoleCmdE;

    // front panel switches, each key is a one clock strobe
    typedef struct packed {
        logic                 loadAddr;
        logic                 deposit;
        logic                 examine;
        logic                 start;
        logic                 cont;
        logic                 stop;
        pdp8IsaPkg::wordT     switchReg;
    } consoleS;

    // panel lights
    typedef struct packed {
        pdp8IsaPkg::wordT     ac;
        pdp8IsaPkg::wordT     ma;
        pdp8IsaPkg::wordT     mb;
        logic                 link;
        pdp8IsaPkg::opcodeE   ir;
        logic                 run;
        logic                 fetch;            // one-hot major state lamps
        logic                 defer;
        logic                 exec;
    } panelS;

endpackage

// ==== logic/pdp8IsaPkg.sv ====
// instruction set package with machine word, opcodes, decoded instruction union and constants
package pdp8IsaPkg;

    typedef logic [11:0] wordT;                 // one 12-bit machine word

    typedef enum logic [2:0] {
        OP_AND = 3'd0,
        OP_TAD = 3'd1,
        OP_ISZ = 3'd2,
        OP_DCA = 3'd3,
        OP_JMS = 3'd4,
        OP_JMP = 3'd5,
        OP_IOT = 3'd6,                          // executes as a no-op here
        OP_OPR = 3'd7
    } opcodeE;

    // memory reference view of an instruction word
    typedef struct packed {
        opcodeE     opcode;
        logic       indirect;                   // bit 8, defer through pointer
        logic       page;                       // bit 7, current page when set
        logic [6:0] offset;                     // word within page
    } memRefS;

    // operate view, group 1 and group 2 names share each bit position
    typedef struct packed {
        opcodeE opcode;
        logic   group;                          // 0 group 1, 1 group 2
        logic   cla;
        logic   cllSma;
        logic   cmaSza;
        logic   cmlSnl;
        logic   rarRev;                         // rar or reverse skip sense
        logic   ralOsr;
        logic   bswHlt;                         // twice/bsw or halt
        logic   iac;                            // must be 0 for group 2
    } operS;

    typedef union packed {
        memRefS memRef;
        operS   operate;
    } instrU;

    localparam int   MEM_WORDS     = 4096;
    localparam wordT AUTO_INDEX_LO = 12'o0010;
    localparam wordT AUTO_INDEX_HI = 12'o0017;
    localparam wordT HLT_MASK      = 12'o7403;  // opcode, group, hlt and iac bits
    localparam wordT HLT_MATCH     = 12'o7402;

endpackage
